// ==== logic/mem_pkg.sv ====
package mem_pkg;

	// ********************
	// bus and memory sizes
	// ********************

	// byte address width on every port
	localparam int ADDR_W = 32;
	// one bus word
	localparam int DATA_W = 64;
	// one enable per byte lane
	localparam int STRB_W = 8;
	// sram depth in 64-bit words
	localparam int MEM_WORDS = 1024;
	// log2 of the depth, so word indices wrap by themselves
	localparam int WORD_IDX_W = 10;
	// arlen field, beats minus one
	localparam int LEN_W = 8;

	// ********************
	// shared types
	// ********************

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [STRB_W-1:0]     strb_t;
	typedef logic [LEN_W-1:0]      burst_len_t;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// arbiter grant, fetch or load/store owns the memory port
	typedef enum logic [1:0] {ARB_IDLE, ARB_FETCH, ARB_DATA} arb_state_t;

	// sram channel state
	typedef enum logic [1:0] {SR_IDLE, SR_READ, SR_WRESP} sram_state_t;

endpackage

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter import mem_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	// fetch requester, read only
	input  addr_t      if_araddr,
	input  burst_len_t if_arlen,
	input  logic       if_arvalid,
	output logic       if_arready,
	output data_t      if_rdata,
	output logic       if_rlast,
	output logic       if_rvalid,
	input  logic       if_rready,
	// load/store requester, read
	input  addr_t      ls_araddr,
	input  logic       ls_arvalid,
	output logic       ls_arready,
	output data_t      ls_rdata,
	output logic       ls_rvalid,
	input  logic       ls_rready,
	// load/store requester, write
	input  addr_t      ls_awaddr,
	input  logic       ls_awvalid,
	output logic       ls_awready,
	input  data_t      ls_wdata,
	input  strb_t      ls_wstrb,
	input  logic       ls_wvalid,
	output logic       ls_wready,
	output logic       ls_bvalid,
	input  logic       ls_bready,
	// memory port toward the sram
	output addr_t      m_araddr,
	output burst_len_t m_arlen,
	output logic       m_arvalid,
	input  logic       m_arready,
	input  data_t      m_rdata,
	input  logic       m_rlast,
	input  logic       m_rvalid,
	output logic       m_rready,
	output addr_t      m_awaddr,
	output logic       m_awvalid,
	input  logic       m_awready,
	output data_t      m_wdata,
	output strb_t      m_wstrb,
	output logic       m_wvalid,
	input  logic       m_wready,
	input  logic       m_bvalid,
	output logic       m_bready
);

	arb_state_t state;
	arb_state_t state_nxt;
	logic       grant_if;
	logic       grant_ls;
	// ending handshakes seen on the memory side
	logic       r_hs;
	logic       b_hs;

	assign grant_if = (state == ARB_FETCH);
	assign grant_ls = (state == ARB_DATA);
	assign r_hs     = m_rvalid && m_rready;
	assign b_hs     = m_bvalid && m_bready;

	// ********************
	// grant fsm
	// ********************

	always_comb begin
		state_nxt = state;
		case (state)
			ARB_IDLE: begin
				// load/store first, it stalls the pipe
				if (ls_arvalid || ls_awvalid) begin
					state_nxt = ARB_DATA;
				end else if (if_arvalid) begin
					state_nxt = ARB_FETCH;
				end
			end
			// hold until the last beat of the burst is taken
			ARB_FETCH: if (r_hs && m_rlast) state_nxt = ARB_IDLE;
			// single read beat or write response ends it
			ARB_DATA:  if (r_hs || b_hs) state_nxt = ARB_IDLE;
			default:   state_nxt = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ARB_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ********************
	// requests to memory
	// ********************

	// load/store reads are always one beat
	assign m_araddr  = grant_ls ? ls_araddr : if_araddr;
	assign m_arlen   = grant_ls ? burst_len_t'(0) : if_arlen;
	assign m_arvalid = (grant_if && if_arvalid) || (grant_ls && ls_arvalid);
	assign m_rready  = (grant_if && if_rready) || (grant_ls && ls_rready);
	// only load/store writes
	assign m_awaddr  = ls_awaddr;
	assign m_awvalid = grant_ls && ls_awvalid;
	assign m_wdata   = ls_wdata;
	assign m_wstrb   = ls_wstrb;
	assign m_wvalid  = grant_ls && ls_wvalid;
	assign m_bready  = grant_ls && ls_bready;

	// ********************
	// responses back
	// ********************

	// data fans out, handshakes masked by grant
	assign if_rdata   = m_rdata;
	assign ls_rdata   = m_rdata;
	assign if_arready = grant_if && m_arready;
	assign if_rvalid  = grant_if && m_rvalid;
	assign if_rlast   = grant_if && m_rlast;
	assign ls_arready = grant_ls && m_arready;
	assign ls_rvalid  = grant_ls && m_rvalid;
	assign ls_awready = grant_ls && m_awready;
	assign ls_wready  = grant_ls && m_wready;
	assign ls_bvalid  = grant_ls && m_bvalid;

endmodule

// ==== logic/sram_slave.sv ====
`timescale 1ns/10ps

module sram_slave import mem_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	// read address
	input  addr_t      m_araddr,
	input  burst_len_t m_arlen,
	input  logic       m_arvalid,
	output logic       m_arready,
	// read data
	output data_t      m_rdata,
	output logic       m_rvalid,
	output logic       m_rlast,
	input  logic       m_rready,
	// write address and data, taken together
	input  addr_t      m_awaddr,
	input  logic       m_awvalid,
	output logic       m_awready,
	input  data_t      m_wdata,
	input  strb_t      m_wstrb,
	input  logic       m_wvalid,
	output logic       m_wready,
	// write response
	output logic       m_bvalid,
	input  logic       m_bready
);

	data_t       mem [MEM_WORDS];
	sram_state_t state;
	// burst position
	word_idx_t   rd_idx;
	word_idx_t   rd_idx_nxt;
	burst_len_t  beats_left;
	// beat on the bus
	data_t       rd_data;
	// word indices from the byte addresses
	word_idx_t   ar_idx;
	word_idx_t   wr_idx;
	logic        ar_hs;
	logic        r_hs;
	logic        w_hs;
	logic        b_hs;

	// byte address to word, upper bits alias
	assign ar_idx     = word_idx_t'(m_araddr >> 3);
	assign wr_idx     = word_idx_t'(m_awaddr >> 3);
	// wraps at the top of the array
	assign rd_idx_nxt = word_idx_t'(rd_idx + 1'b1);

	// ********************
	// channel handshakes
	// ********************

	assign m_arready = (state == SR_IDLE);
	assign m_awready = (state == SR_IDLE);
	assign m_wready  = (state == SR_IDLE);

	assign ar_hs = m_arvalid && m_arready;
	// write needs both channels, read wins if both ever appear
	assign w_hs  = m_awvalid && m_awready && m_wvalid && m_wready && !m_arvalid;
	assign r_hs  = m_rvalid && m_rready;
	assign b_hs  = m_bvalid && m_bready;

	assign m_rvalid = (state == SR_READ);
	assign m_rlast  = m_rvalid && (beats_left == '0);
	assign m_rdata  = rd_data;
	assign m_bvalid = (state == SR_WRESP);

	// ********************
	// control fsm
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= SR_IDLE;
			rd_idx     <= '0;
			beats_left <= '0;
		end else begin
			case (state)
				SR_IDLE: begin
					if (ar_hs) begin
						state      <= SR_READ;
						rd_idx     <= ar_idx;
						beats_left <= m_arlen;
					end else if (w_hs) begin
						state <= SR_WRESP;
					end
				end
				SR_READ: begin
					// advance only on a taken beat
					if (r_hs) begin
						if (beats_left == '0) begin
							state <= SR_IDLE;
						end else begin
							rd_idx     <= rd_idx_nxt;
							beats_left <= beats_left - 1'b1;
						end
					end
				end
				// hold response until taken
				SR_WRESP: if (b_hs) state <= SR_IDLE;
				default:  state <= SR_IDLE;
			endcase
		end
	end

	// ********************
	// array and data path
	// ********************

	// first beat on the address, next beat on each taken beat
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_data <= mem[ar_idx];
		end else if (r_hs) begin
			rd_data <= mem[rd_idx_nxt];
		end
	end

	// byte merge, untouched lanes keep old value
	always_ff @(posedge clk) begin
		if (w_hs) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (m_wstrb[b]) begin
					mem[wr_idx][b*8 +: 8] <= m_wdata[b*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== logic/mem_system_top.sv ====
`timescale 1ns/10ps

module mem_system_top import mem_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	// fetch port
	input  addr_t      if_araddr,
	input  burst_len_t if_arlen,
	input  logic       if_arvalid,
	output logic       if_arready,
	output data_t      if_rdata,
	output logic       if_rlast,
	output logic       if_rvalid,
	input  logic       if_rready,
	// load/store port
	input  addr_t      ls_araddr,
	input  logic       ls_arvalid,
	output logic       ls_arready,
	output data_t      ls_rdata,
	output logic       ls_rvalid,
	input  logic       ls_rready,
	input  addr_t      ls_awaddr,
	input  logic       ls_awvalid,
	output logic       ls_awready,
	input  data_t      ls_wdata,
	input  strb_t      ls_wstrb,
	input  logic       ls_wvalid,
	output logic       ls_wready,
	output logic       ls_bvalid,
	input  logic       ls_bready
);

	// ********************
	// arbiter to sram
	// ********************

	addr_t      m_araddr;
	burst_len_t m_arlen;
	logic       m_arvalid;
	logic       m_arready;
	data_t      m_rdata;
	logic       m_rlast;
	logic       m_rvalid;
	logic       m_rready;
	addr_t      m_awaddr;
	logic       m_awvalid;
	logic       m_awready;
	data_t      m_wdata;
	strb_t      m_wstrb;
	logic       m_wvalid;
	logic       m_wready;
	logic       m_bvalid;
	logic       m_bready;

	// port names match the wires one to one
	bus_arbiter u_arbiter (.*);

	// single-port memory behind the arbiter
	sram_slave u_sram (.*);

endmodule

// ==== dv/mem_system_sva.sv ====
`timescale 1ns/10ps

module mem_system_sva import mem_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  if_arready,
	input logic  if_rvalid,
	input logic  if_rready,
	input logic  if_rlast,
	input data_t if_rdata,
	input logic  ls_arready,
	input logic  ls_rvalid,
	input logic  ls_rready,
	input data_t ls_rdata,
	input logic  ls_awvalid,
	input logic  ls_awready,
	input logic  ls_wvalid,
	input logic  ls_wready,
	input logic  ls_bvalid
);

	// held beat keeps its data
	assert property (@(posedge clk) disable iff (rst)
		if_rvalid && !if_rready |=> if_rvalid && $stable(if_rdata))
		else $error("fetch beat changed while held");
	assert property (@(posedge clk) disable iff (rst)
		ls_rvalid && !ls_rready |=> ls_rvalid && $stable(ls_rdata))
		else $error("load beat changed while held");

	// one grant at a time
	assert property (@(posedge clk) disable iff (rst) !(if_rvalid && ls_rvalid))
		else $error("both read channels valid");

	// quiet once reset has been seen
	assert property (@(posedge clk) $past(rst) |-> !(if_arready || if_rvalid || if_rlast
		|| ls_arready || ls_rvalid || ls_awready || ls_wready || ls_bvalid))
		else $error("handshake output high in reset");

	// response one cycle after the write
	assert property (@(posedge clk) disable iff (rst)
		ls_awvalid && ls_awready && ls_wvalid && ls_wready |=> ls_bvalid)
		else $error("no write response");

endmodule

bind mem_system_top mem_system_sva u_sva (.*);

// ==== dv/mem_system_tb.sv ====
`timescale 1ns/10ps

module mem_system_tb import mem_pkg::*; ();

	logic       clk = 1'b0;
	logic       rst;
	addr_t      if_araddr;
	burst_len_t if_arlen;
	logic       if_arvalid;
	logic       if_arready;
	data_t      if_rdata;
	logic       if_rlast;
	logic       if_rvalid;
	logic       if_rready;
	addr_t      ls_araddr;
	logic       ls_arvalid;
	logic       ls_arready;
	data_t      ls_rdata;
	logic       ls_rvalid;
	logic       ls_rready;
	addr_t      ls_awaddr;
	logic       ls_awvalid;
	logic       ls_awready;
	data_t      ls_wdata;
	strb_t      ls_wstrb;
	logic       ls_wvalid;
	logic       ls_wready;
	logic       ls_bvalid;
	logic       ls_bready;

	// shadow of the sram contents
	data_t      shadow [MEM_WORDS];
	// expected beats in issue order
	data_t      if_exp [$];
	bit         if_last_exp [$];
	data_t      ls_exp [$];
	logic [31:0] rng;
	int         cycles = 0;
	int         beats_issued;
	int         ls_beat_cyc;
	int         if_first_cyc;

	mem_system_top DUT (.*);

	// ********************
	// clock and timeout
	// ********************

	initial begin
		forever #50 clk = ~clk;
	end

	// limit grows with the traffic issued so far
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 20 * beats_issued + 200) begin
			fail_with("timeout, a handshake never completed");
		end
	end

	// ********************
	// helpers
	// ********************

	task automatic fail_with(string msg);
		$display("%s at %0t", msg, $time);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(string name, data_t got, data_t exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			fail_with("value mismatch");
		end
	endtask

	// xorshift32 step
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic pick_ready(bit gaps);
		if (!gaps) return 1'b1;
		return (next_rand() % 4) != 0;
	endfunction

	// strobe merge rule, one byte lane per strobe bit
	function automatic data_t ref_merge(data_t old, data_t wdata, strb_t strb);
		data_t res;
		res = old;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic check_idle();
		check_value("if_arready", data_t'(if_arready), '0);
		check_value("if_rvalid", data_t'(if_rvalid), '0);
		check_value("if_rlast", data_t'(if_rlast), '0);
		check_value("ls_arready", data_t'(ls_arready), '0);
		check_value("ls_rvalid", data_t'(ls_rvalid), '0);
		check_value("ls_awready", data_t'(ls_awready), '0);
		check_value("ls_wready", data_t'(ls_wready), '0);
		check_value("ls_bvalid", data_t'(ls_bvalid), '0);
	endtask

	// ********************
	// requester drivers
	// ********************

	task automatic fetch_burst(addr_t addr, burst_len_t len, bit gaps);
		word_idx_t idx;
		bit        done;
		idx = word_idx_t'(addr >> 3);
		for (int i = 0; i <= int'(len); i++) begin
			if_exp.push_back(shadow[word_idx_t'(idx + i)]);
			if_last_exp.push_back(i == int'(len));
		end
		beats_issued = beats_issued + int'(len) + 1;
		@(negedge clk);
		if_araddr  = addr;
		if_arlen   = len;
		if_arvalid = 1'b1;
		do @(posedge clk); while (!if_arready);
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if_arvalid = 1'b0;
			if_rready  = pick_ready(gaps);
			@(posedge clk);
			if (if_rvalid && if_rready && if_rlast) done = 1'b1;
		end
		@(negedge clk);
		if_rready = 1'b0;
	endtask

	task automatic ls_read(addr_t addr, bit gaps);
		bit done;
		ls_exp.push_back(shadow[word_idx_t'(addr >> 3)]);
		beats_issued = beats_issued + 1;
		@(negedge clk);
		ls_araddr  = addr;
		ls_arvalid = 1'b1;
		do @(posedge clk); while (!ls_arready);
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			ls_arvalid = 1'b0;
			ls_rready  = pick_ready(gaps);
			@(posedge clk);
			if (ls_rvalid && ls_rready) done = 1'b1;
		end
		@(negedge clk);
		ls_rready = 1'b0;
	endtask

	task automatic ls_write(addr_t addr, data_t data, strb_t strb, bit gaps);
		word_idx_t idx;
		bit        done;
		idx = word_idx_t'(addr >> 3);
		beats_issued = beats_issued + 1;
		@(negedge clk);
		ls_awaddr  = addr;
		ls_wdata   = data;
		ls_wstrb   = strb;
		ls_awvalid = 1'b1;
		ls_wvalid  = 1'b1;
		do @(posedge clk); while (!(ls_awready && ls_wready));
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			ls_awvalid = 1'b0;
			ls_wvalid  = 1'b0;
			ls_bready  = pick_ready(gaps);
			@(posedge clk);
			if (ls_bvalid && ls_bready) done = 1'b1;
		end
		// shadow follows the b handshake
		shadow[idx] = ref_merge(shadow[idx], data, strb);
		@(negedge clk);
		ls_bready = 1'b0;
	endtask

	// ********************
	// compare process
	// ********************

	always @(posedge clk) begin
		if (!rst) begin
			if (if_rvalid && if_first_cyc == 0) if_first_cyc = cycles;
			if (if_rvalid && if_rready) begin
				if (if_exp.size() == 0) fail_with("fetch beat with no request open");
				check_value("if_rdata", if_rdata, if_exp.pop_front());
				check_value("if_rlast", data_t'(if_rlast), data_t'(if_last_exp.pop_front()));
			end
			if (ls_rvalid && ls_rready) begin
				if (ls_exp.size() == 0) fail_with("load beat with no request open");
				check_value("ls_rdata", ls_rdata, ls_exp.pop_front());
				ls_beat_cyc = cycles;
			end
		end
	end

	// ********************
	// test sequence
	// ********************

	initial begin
		rng = 32'hf823d451;
		beats_issued = 0;
		ls_beat_cyc = 0;
		if_first_cyc = 0;
		rst = 1'b1;
		if_araddr = '0;
		if_arlen = '0;
		if_arvalid = 1'b0;
		if_rready = 1'b0;
		ls_araddr = '0;
		ls_arvalid = 1'b0;
		ls_rready = 1'b0;
		ls_awaddr = '0;
		ls_awvalid = 1'b0;
		ls_wdata = '0;
		ls_wstrb = '0;
		ls_wvalid = 1'b0;
		ls_bready = 1'b0;
		// outputs quiet in reset and just after
		repeat (5) begin
			@(negedge clk);
			check_idle();
		end
		rst = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_idle();
		end
		// fill every word, pattern from the whole address
		for (int i = 0; i < MEM_WORDS; i++) begin
			ls_write(addr_t'(i * 8), {32'(i) * 32'h9e3779b9, ~32'(i)}, '1, 1'b0);
		end
		// full then partial writes, read back
		for (int i = 0; i < 16; i++) begin
			addr_t a;
			a = next_rand();
			ls_write(a, {next_rand(), next_rand()}, '1, 1'b0);
			ls_write(a, {next_rand(), next_rand()}, strb_t'(next_rand()), 1'b0);
			ls_read(a, 1'b0);
		end
		// bursts, one forced across the top of the array
		fetch_burst(addr_t'((MEM_WORDS - 3) * 8), burst_len_t'(7), 1'b0);
		for (int i = 0; i < 12; i++) begin
			fetch_burst(next_rand(), burst_len_t'(next_rand() % 16), 1'b0);
		end
		// same-edge contention, load/store must win
		for (int i = 0; i < 4; i++) begin
			if_first_cyc = 0;
			ls_beat_cyc = 0;
			fork
				fetch_burst(next_rand(), burst_len_t'(next_rand() % 8), 1'b0);
				ls_read(next_rand(), 1'b0);
			join
			if (!(ls_beat_cyc < if_first_cyc)) begin
				fail_with("fetch data came before the load/store response");
			end
		end
		// back-pressure on both sides
		for (int i = 0; i < 20; i++) begin
			fork
				fetch_burst(next_rand(), burst_len_t'(next_rand() % 16), 1'b1);
				ls_read(next_rand(), 1'b1);
			join
			ls_write(next_rand(), {next_rand(), next_rand()}, strb_t'(next_rand()), 1'b1);
		end
		// long random mix
		for (int i = 0; i < 300; i++) begin
			case (next_rand() % 3)
				0: fetch_burst(next_rand(), burst_len_t'(next_rand() % 16), next_rand() % 2 == 0);
				1: ls_read(next_rand(), next_rand() % 2 == 0);
				default: ls_write(next_rand(), {next_rand(), next_rand()},
					strb_t'(next_rand()), next_rand() % 2 == 0);
			endcase
		end
		repeat (4) @(negedge clk);
		if (if_exp.size() != 0 || ls_exp.size() != 0) begin
			fail_with("beats still missing at the end");
		end else begin
			$display("Test OK");
		end
		$finish;
	end

endmodule

// ==== files.f ====
logic/mem_pkg.sv
logic/bus_arbiter.sv
logic/sram_slave.sv
logic/mem_system_top.sv
dv/mem_system_sva.sv
dv/mem_system_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mem_system_tb \
	--Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
fi

if grep -q "^Test OK$" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see sim.log"
exit 1
